// ==== hdl/audio_udp_pkg.sv ====
// audio udp shared types
`default_nettype none

package audio_udp_pkg;

   // payload widths
   typedef logic [15:0] sample_t;    // one audio sample
   typedef logic [31:0] word_t;      // earlier sample in [31:16], network order
   typedef logic [6:0]  level_t;     // fifo fill count, 0..64
   typedef logic [15:0] byte_num_t;  // udp payload length in bytes

   // packet sender fsm
   typedef enum logic [1:0] {
      s_idle,       // waiting for a packet's worth of words
      s_start,      // start strobe on the wire
      s_send,       // serving engine requests
      s_wait_done   // all words out, engine still busy
   } send_state_t;

   // sample pacing
   localparam int SAMPLE_DIV = 4;                    // clocks per sample
   localparam int DIV_W      = $clog2(SAMPLE_DIV);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);

   // buffer
   localparam level_t FIFO_DEPTH = 7'd64;            // words
   localparam int     PTR_W      = $clog2(FIFO_DEPTH);

   // packet shape
   localparam level_t    PKT_WORDS = 7'd8;           // words per packet
   // four bytes per payload word
   localparam byte_num_t PKT_BYTES = byte_num_t'(4 * PKT_WORDS);

endpackage

`default_nettype wire

// ==== hdl/audio_sample_gen.sv ====
// ramp audio sample source
`timescale 1ns/1ps
`default_nettype none

// stands in for a real codec interface
// data is a plain counter so packet content is predictable
module audio_sample_gen
(
   input  wire logic                  clk_12M,
   input  wire logic                  rst_n,
   input  wire logic                  run,         // level, pauses the ramp when low
   output logic                       audio_en,    // one-cycle sample strobe
   output audio_udp_pkg::sample_t     audio_data   // valid with audio_en
);

   logic [audio_udp_pkg::DIV_W-1:0] div_cnt;    // clocks since last strobe

   // divider, restarts from zero whenever run drops
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         div_cnt <= '0;
      end
      else if (!run)
      begin
         div_cnt <= '0;                          // next strobe a full period after run
      end
      else if (div_cnt == audio_udp_pkg::DIV_LAST)
      begin
         div_cnt <= '0;
      end
      else
      begin
         div_cnt <= div_cnt + audio_udp_pkg::DIV_W'(1);
      end
   end

   // strobe lands SAMPLE_DIV clocks after run is first seen
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         audio_en <= 1'b0;
      end
      else
      begin
         audio_en <= run && (div_cnt == audio_udp_pkg::DIV_LAST);
      end
   end

   // ramp value, steps once the current sample has been strobed out
   // keeps its value across pauses of run
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         audio_data <= '0;                       // first sample is 0
      end
      else if (audio_en)
      begin
         audio_data <= audio_data + audio_udp_pkg::sample_t'(1);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
// sample pair packing fifo
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
(
   input  wire logic                     clk_12M,
   input  wire logic                     rst_n,
   input  wire logic                     audio_en,     // sample strobe, no back-pressure
   input  wire audio_udp_pkg::sample_t   audio_data,
   input  wire logic                     rd_en,        // pop head word
   output audio_udp_pkg::word_t          rd_data,      // head word, show-ahead
   output audio_udp_pkg::level_t         level,        // registered word count
   output logic                          overflow      // sticky, cleared by reset only
);

   audio_udp_pkg::sample_t hi_q;       // first sample of the pair
   logic                   phase;      // 1: holding the upper half
   logic                   wr_en;      // word complete, write this cycle
   audio_udp_pkg::word_t   wr_word;
   logic                   full;
   logic                   do_wr;
   logic                   do_rd;

   logic [audio_udp_pkg::PTR_W-1:0] wr_ptr;
   logic [audio_udp_pkg::PTR_W-1:0] rd_ptr;

   audio_udp_pkg::word_t mem [audio_udp_pkg::FIFO_DEPTH];

   assign full  = (level == audio_udp_pkg::FIFO_DEPTH);
   assign do_wr = wr_en && !full;                   // word dropped when full
   assign do_rd = rd_en && (level != '0);

   // pair packing, earlier sample goes high
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase <= 1'b0;
         wr_en <= 1'b0;
      end
      else
      begin
         wr_en <= audio_en && phase;               // second sample closes the word
         if (audio_en)
         begin
            phase <= !phase;
         end
      end
   end

   always_ff @(posedge clk_12M)
   begin
      if (audio_en && !phase)
      begin
         hi_q <= audio_data;
      end
      if (audio_en && phase)
      begin
         wr_word <= {hi_q, audio_data};
      end
   end

   // storage, pointers wrap on their own since depth is a power of two
   always_ff @(posedge clk_12M)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wr_word;
      end
   end

   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + audio_udp_pkg::PTR_W'(1);
         if (do_rd)
            rd_ptr <= rd_ptr + audio_udp_pkg::PTR_W'(1);
         if (wr_en && full)
            overflow <= 1'b1;                       // lost a word
         unique case ({do_wr, do_rd})
            2'b10:   level <= level + audio_udp_pkg::level_t'(1);
            2'b01:   level <= level - audio_udp_pkg::level_t'(1);
            default: level <= level;                // idle or push+pop
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/audio_pkt_sender.sv ====
// udp packet sender
`timescale 1ns/1ps
`default_nettype none

// offers fixed-size packets to the udp transmit engine
// one fifo word per engine request, word on tx_data the cycle after
module audio_pkt_sender
(
   input  wire logic                     clk_12M,
   input  wire logic                     rst_n,
   input  wire logic                     transfer_flag,  // low blocks new packets only
   input  wire audio_udp_pkg::level_t    level,
   input  wire audio_udp_pkg::word_t     rd_data,
   input  wire logic                     tx_req,         // engine wants next word
   input  wire logic                     tx_done,        // engine finished packet
   output logic                          rd_en,
   output logic                          tx_start_en,
   output audio_udp_pkg::word_t          tx_data,
   output audio_udp_pkg::byte_num_t      tx_byte_num
);

   audio_udp_pkg::send_state_t state;
   audio_udp_pkg::level_t      word_cnt;     // requests served this packet
   logic                       pkt_ready;
   logic                       last_word;

   // fixed length, held for the whole packet
   assign tx_byte_num = audio_udp_pkg::PKT_BYTES;

   assign pkt_ready = transfer_flag && (level >= audio_udp_pkg::PKT_WORDS);
   assign last_word = (word_cnt == audio_udp_pkg::PKT_WORDS - audio_udp_pkg::level_t'(1));

   // pop in the request cycle, extra requests fall through
   // a whole packet is queued before the start, so the fifo cannot run dry
   assign rd_en = (state == audio_udp_pkg::s_send) && tx_req;

   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= audio_udp_pkg::s_idle;
         word_cnt    <= '0;
         tx_start_en <= 1'b0;
         tx_data     <= '0;
      end
      else
      begin
         tx_start_en <= 1'b0;                        // single-cycle pulse
         if (rd_en)
         begin
            tx_data  <= rd_data;                     // head word, one cycle after req
            word_cnt <= word_cnt + audio_udp_pkg::level_t'(1);
         end
         case (state)
            audio_udp_pkg::s_idle:
            begin
               word_cnt <= '0;
               if (pkt_ready)
               begin
                  tx_start_en <= 1'b1;
                  state       <= audio_udp_pkg::s_start;
               end
            end
            audio_udp_pkg::s_start:
            begin
               state <= audio_udp_pkg::s_send;       // strobe seen by engine
            end
            audio_udp_pkg::s_send:
            begin
               if (tx_done)
                  state <= audio_udp_pkg::s_idle;    // engine ended early
               else if (rd_en && last_word)
                  state <= audio_udp_pkg::s_wait_done;
            end
            audio_udp_pkg::s_wait_done:
            begin
               if (tx_done)
                  state <= audio_udp_pkg::s_idle;
            end
            default:
            begin
               state <= audio_udp_pkg::s_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/audio_udp_tx.sv ====
// audio over udp transmit top
`timescale 1ns/1ps
`default_nettype none

module audio_udp_tx
(
   input  wire logic                     clk_12M,
   input  wire logic                     rst_n,
   input  wire logic                     run,            // source enable
   input  wire logic                     transfer_flag,  // packet gate
   input  wire logic                     tx_req,         // from udp engine
   input  wire logic                     tx_done,        // from udp engine
   output logic                          tx_start_en,
   output audio_udp_pkg::word_t          tx_data,
   output audio_udp_pkg::byte_num_t      tx_byte_num,
   output logic                          overflow        // fifo dropped a word
);

   logic                     audio_en;
   audio_udp_pkg::sample_t   audio_data;
   logic                     rd_en;
   audio_udp_pkg::word_t     rd_data;
   audio_udp_pkg::level_t    level;

   audio_sample_gen u_sample_gen (
      .clk_12M       (clk_12M),
      .rst_n         (rst_n),
      .run           (run),
      .audio_en      (audio_en),
      .audio_data    (audio_data)
   );

   sample_fifo u_sample_fifo (
      .clk_12M       (clk_12M),
      .rst_n         (rst_n),
      .audio_en      (audio_en),
      .audio_data    (audio_data),
      .rd_en         (rd_en),       // pop from sender
      .rd_data       (rd_data),     // show-ahead head
      .level         (level),
      .overflow      (overflow)
   );

   audio_pkt_sender u_pkt_sender (
      .clk_12M       (clk_12M),
      .rst_n         (rst_n),
      .transfer_flag (transfer_flag),
      .level         (level),
      .rd_data       (rd_data),
      .tx_req        (tx_req),
      .tx_done       (tx_done),
      .rd_en         (rd_en),
      .tx_start_en   (tx_start_en),
      .tx_data       (tx_data),
      .tx_byte_num   (tx_byte_num)
   );

endmodule

`default_nettype wire

// ==== verif/audio_udp_tx_assertions.sv ====
// packet sender strobe checks
`timescale 1ns/1ps
`default_nettype none

module audio_udp_tx_assertions
(
   input  wire logic                        clk_12M,
   input  wire logic                        rst_n,
   input  wire audio_udp_pkg::send_state_t  state,
   input  wire audio_udp_pkg::level_t       level,
   input  wire logic                        rd_en,
   input  wire logic                        tx_start_en
);

   int unsigned fail_cnt = 0;   // failures seen, polled by the testbench

   // start strobe is a single cycle
   start_one_cycle: assert property (@(posedge clk_12M) disable iff (!rst_n)
      tx_start_en |=> !tx_start_en)
   else
   begin
      fail_cnt++;
      $error("tx_start_en held for more than one cycle");
   end

   // no new start while a packet is in flight
   start_from_idle: assert property (@(posedge clk_12M) disable iff (!rst_n)
      (state != audio_udp_pkg::s_idle) |=> !tx_start_en)
   else
   begin
      fail_cnt++;
      $error("tx_start_en while the sender was busy");
   end

   // never pop an empty fifo
   no_pop_empty: assert property (@(posedge clk_12M) disable iff (!rst_n)
      rd_en |-> (level != '0))
   else
   begin
      fail_cnt++;
      $error("rd_en with an empty fifo");
   end

endmodule

bind audio_pkt_sender audio_udp_tx_assertions u_sender_assertions (
   .clk_12M     (clk_12M),
   .rst_n       (rst_n),
   .state       (state),
   .level       (level),
   .rd_en       (rd_en),
   .tx_start_en (tx_start_en)
);

`default_nettype wire

// ==== verif/audio_udp_tx_tb.sv ====
// audio udp transmit testbench
`timescale 1ns/1ps
`default_nettype none

module audio_udp_tx_tb;

   localparam int CLK_HALF      = 50;     // 100 ns period
   localparam int START_TIMEOUT = 400;    // cycles to wait for a start pulse
   // long enough for PKT_WORDS plus margin to pile up
   localparam int IDLE_WINDOW   = (int'(audio_udp_pkg::PKT_WORDS) + 2) * 2
                                  * audio_udp_pkg::SAMPLE_DIV;
   // engine stall that overruns the fifo
   localparam int STALL_CYCLES  = (int'(audio_udp_pkg::FIFO_DEPTH) + 4) * 2
                                  * audio_udp_pkg::SAMPLE_DIV;
   // payload length from the word width, 8 bits per byte
   localparam int EXP_BYTE_NUM  = int'(audio_udp_pkg::PKT_WORDS)
                                  * $bits(audio_udp_pkg::word_t) / 8;

   typedef struct packed {
      logic       run;
      logic       flag;      // transfer_flag
      logic [3:0] pkts;      // packets to serve, 0 means watch for no start
      logic       stall;
      logic       ovf;       // expected overflow at end of row
   } row_t;

   localparam int NROWS = 6;
   localparam row_t ROWS [NROWS] = '{
      '{1'b1, 1'b1, 4'd3, 1'b0, 1'b0},   // from reset, ramp from sample 0
      '{1'b1, 1'b0, 4'd0, 1'b0, 1'b0},   // gate closed
      '{1'b1, 1'b1, 4'd3, 1'b0, 1'b0},   // gate open again
      '{1'b0, 1'b1, 4'd0, 1'b0, 1'b0},   // source paused
      '{1'b1, 1'b1, 4'd2, 1'b0, 1'b0},   // source resumed
      '{1'b1, 1'b1, 4'd1, 1'b1, 1'b1}    // slow engine
   };

   logic                       clk_12M;
   logic                       rst_n;
   logic                       run;
   logic                       transfer_flag;
   logic                       tx_req;
   logic                       tx_done;
   logic                       tx_start_en;
   audio_udp_pkg::word_t       tx_data;
   audio_udp_pkg::byte_num_t   tx_byte_num;
   logic                       overflow;

   audio_udp_pkg::sample_t     next_sample;   // model ramp, next expected sample

   audio_udp_tx u_audio_udp_tx (
      .clk_12M       (clk_12M),
      .rst_n         (rst_n),
      .run           (run),
      .transfer_flag (transfer_flag),
      .tx_req        (tx_req),
      .tx_done       (tx_done),
      .tx_start_en   (tx_start_en),
      .tx_data       (tx_data),
      .tx_byte_num   (tx_byte_num),
      .overflow      (overflow)
   );

   initial
   begin
      clk_12M = 1'b0;
      forever #CLK_HALF clk_12M = ~clk_12M;
   end

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input audio_udp_pkg::word_t got, input audio_udp_pkg::word_t exp,
                             input string what);
      if (got !== exp)
         fail_stop($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_byte_num(input audio_udp_pkg::byte_num_t got,
                                 input audio_udp_pkg::byte_num_t exp, input string what);
      if (got !== exp)
         fail_stop($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
         fail_stop($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic apply_reset();
      @(posedge clk_12M);
      rst_n         <= 1'b0;
      run           <= 1'b0;
      transfer_flag <= 1'b0;
      tx_req        <= 1'b0;
      tx_done       <= 1'b0;
      repeat (2) @(posedge clk_12M);
      rst_n <= 1'b1;
      next_sample = '0;             // ramp restarts at 0
   endtask

   task automatic check_reset_state();
      @(negedge clk_12M);
      check_flag(tx_start_en, 1'b0, "tx_start_en after reset");
      check_word(tx_data, '0, "tx_data after reset");
      check_flag(overflow, 1'b0, "overflow after reset");
   endtask

   task automatic wait_start();
      for (int n = 0; n < START_TIMEOUT; n++)
      begin
         @(negedge clk_12M);
         if (tx_start_en)
            return;
      end
      fail_stop("timeout while waiting for tx_start_en from the sender");
   endtask

   // sender must stay quiet for the whole window
   task automatic watch_no_start(input string what);
      for (int n = 0; n < IDLE_WINDOW; n++)
      begin
         @(negedge clk_12M);
         if (tx_start_en)
            fail_stop($sformatf("unexpected tx_start_en at %0t during %s", $time, what));
      end
   endtask

   // udp engine model, one packet
   task automatic serve_packet(input logic stall);
      int unsigned          gap;
      audio_udp_pkg::word_t exp_word;
      wait_start();
      check_byte_num(tx_byte_num, audio_udp_pkg::byte_num_t'(EXP_BYTE_NUM),
                     "tx_byte_num at start");
      if (stall)
         repeat (STALL_CYCLES) @(posedge clk_12M);   // let the fifo overrun
      for (int i = 0; i < int'(audio_udp_pkg::PKT_WORDS); i++)
      begin
         @(posedge clk_12M);
         tx_req <= 1'b1;
         @(posedge clk_12M);
         tx_req <= 1'b0;
         @(negedge clk_12M);                  // word registered on that edge
         exp_word = {next_sample, next_sample + audio_udp_pkg::sample_t'(1)};
         check_word(tx_data, exp_word, "tx_data");
         next_sample = next_sample + audio_udp_pkg::sample_t'(2);
         gap = $urandom_range(3, 0);
         repeat (gap) @(posedge clk_12M);
      end
      @(posedge clk_12M);
      tx_done <= 1'b1;
      @(posedge clk_12M);
      tx_done <= 1'b0;
   endtask

   initial
   begin
      rst_n         = 1'b0;
      run           = 1'b0;
      transfer_flag = 1'b0;
      tx_req        = 1'b0;
      tx_done       = 1'b0;
      next_sample   = '0;
      void'($urandom(32'h65b2));
      apply_reset();
      check_reset_state();

      for (int r = 0; r < NROWS; r++)
      begin
         @(posedge clk_12M);
         run           <= ROWS[r].run;
         transfer_flag <= ROWS[r].flag;
         if (ROWS[r].pkts == 4'd0)
            watch_no_start($sformatf("row %0d", r));
         for (int p = 0; p < int'(ROWS[r].pkts); p++)
            serve_packet(ROWS[r].stall);
         check_flag(overflow, ROWS[r].ovf, $sformatf("overflow after row %0d", r));
      end

      // sticky until reset
      repeat (4) @(posedge clk_12M);
      check_flag(overflow, 1'b1, "overflow before reset");
      apply_reset();
      check_reset_state();

      if (u_audio_udp_tx.u_pkt_sender.u_sender_assertions.fail_cnt == 0)
      begin
         $display("Verification passed");
         $finish;
      end
      else
      begin
         fail_stop("assertion failures on the sender strobes");
      end
   end

endmodule

`default_nettype wire

// ==== audio_udp_tx.f ====
hdl/audio_udp_pkg.sv
hdl/audio_sample_gen.sv
hdl/sample_fifo.sv
hdl/audio_pkt_sender.sv
hdl/audio_udp_tx.sv
verif/audio_udp_tx_assertions.sv
verif/audio_udp_tx_tb.sv

// ==== Makefile ====
# Verilator build and run of the audio udp transmit testbench

VERILATOR ?= verilator
TOP       ?= audio_udp_tx_tb
FILELIST  ?= audio_udp_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
